// File: flist.f
+incdir+src
src/axil_pkg.sv
src/dma_desc_pkg.sv
src/axil_reg_ctrl.sv
src/dma_desc_regs.sv
src/tlp_counters.sv
src/error_pulse_merge.sv
src/dma_ctrl_top.sv
bench/tb_dma_ctrl.sv

// File: Makefile
# Verilator build and run of the DMA host control testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run tb_dma_ctrl with Verilator, log in sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dma_ctrl -f flist.f
	./obj_dir/Vtb_dma_ctrl | tee sim.log
	@if grep -q "Simulation failed" sim.log; then \
		echo "test FAILED"; exit 1; \
	elif ! grep -q "Simulation completed successfully" sim.log; then \
		echo "test FAILED, run ended early"; exit 1; \
	else \
		echo "test PASSED"; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: bench/tb_dma_ctrl.sv
`timescale 1ns/100ps

`include "dma_ctrl_defs.svh"

module tb_dma_ctrl;

    // wide margin over roughly 800 cycles of traffic
    localparam int timeout_cycles = 4000;

    logic                        clk = 1'b0;
    logic                        rst;
    axil_pkg::axil_req_t         axil_req;
    axil_pkg::axil_rsp_t         axil_rsp;
    logic                        dma_enable;
    dma_desc_pkg::dma_desc_t     read_desc;
    logic                        read_desc_valid;
    logic                        read_desc_ready;
    dma_desc_pkg::desc_status_t  read_status;
    logic                        read_status_ready;
    dma_desc_pkg::dma_desc_t     write_desc;
    logic                        write_desc_valid;
    logic                        write_desc_ready;
    dma_desc_pkg::desc_status_t  write_status;
    logic                        write_status_ready;
    dma_desc_pkg::tlp_streams_t  streams;
    logic [`ERR_SOURCES-1:0]     err_cor;
    logic [`ERR_SOURCES-1:0]     err_uncor;
    logic                        status_error_cor;
    logic                        status_error_uncor;
    logic                        irq;

    int errors = 0;
    int checks = 0;
    int cycle_count = 0;
    int cor_in = 0;
    int uncor_in = 0;
    int cor_out = 0;
    int uncor_out = 0;
    int rd_pops = 0;
    int wr_pops = 0;

    // testbench mirror of the register state
    logic                     en_m = 1'b0;
    axil_pkg::axil_data_t     cnt_m [4] = '{default: '0};
    dma_desc_pkg::dma_desc_t  exp_desc [2];
    logic [15:0]              rd_offset = '0;

    dma_ctrl_top dut_i (
        .clk                (clk),
        .rst                (rst),
        .axil_req           (axil_req),
        .axil_rsp           (axil_rsp),
        .dma_enable         (dma_enable),
        .read_desc          (read_desc),
        .read_desc_valid    (read_desc_valid),
        .read_desc_ready    (read_desc_ready),
        .read_status        (read_status),
        .read_status_ready  (read_status_ready),
        .write_desc         (write_desc),
        .write_desc_valid   (write_desc_valid),
        .write_desc_ready   (write_desc_ready),
        .write_status       (write_status),
        .write_status_ready (write_status_ready),
        .streams            (streams),
        .err_cor            (err_cor),
        .err_uncor          (err_uncor),
        .status_error_cor   (status_error_cor),
        .status_error_uncor (status_error_uncor),
        .irq                (irq)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s", $time, msg);
        end
    endtask

    // read word as the register map defines it
    function automatic axil_pkg::axil_data_t expected_read(input logic [15:0] offset);
        axil_pkg::axil_data_t word;
        word = '0;
        case (offset)
            `REG_ENABLE: word[0] = en_m;
            `REG_RD_STATUS: begin
                word[7:0] = read_status.tag;
                word[`STATUS_VALID_BIT] = read_status.valid;
            end
            `REG_WR_STATUS: begin
                word[7:0] = write_status.tag;
                word[`STATUS_VALID_BIT] = write_status.valid;
            end
            `REG_CNT_RQ: word = cnt_m[0];
            `REG_CNT_RC: word = cnt_m[1];
            `REG_CNT_CQ: word = cnt_m[2];
            `REG_CNT_CC: word = cnt_m[3];
            default: word = '0;
        endcase
        return word;
    endfunction

    function automatic logic completes(input dma_desc_pkg::tlp_beat_t b);
        return b.valid && b.ready && b.last;
    endfunction

    function automatic logic desc_valid(input int ch);
        return (ch == 0) ? read_desc_valid : write_desc_valid;
    endfunction

    // compare every read response and every offered descriptor
    always @(negedge clk) begin
        if (!rst) begin
            if (axil_rsp.rvalid && axil_req.rready) begin
                check(axil_rsp.rdata === expected_read(rd_offset),
                      $sformatf("read of 0x%h returned 0x%h, expected 0x%h", rd_offset,
                                axil_rsp.rdata, expected_read(rd_offset)));
            end
            if (read_desc_valid) begin
                check(read_desc === exp_desc[0],
                      $sformatf("read descriptor 0x%h, expected 0x%h", read_desc, exp_desc[0]));
            end
            if (write_desc_valid) begin
                check(write_desc === exp_desc[1],
                      $sformatf("write descriptor 0x%h, expected 0x%h", write_desc, exp_desc[1]));
            end
        end
    end

    // pulse counters for status pops and merged errors
    always @(negedge clk) begin
        if (!rst) begin
            if (read_status_ready) rd_pops++;
            if (write_status_ready) wr_pops++;
            if (status_error_cor) cor_out++;
            if (status_error_uncor) uncor_out++;
        end
    end

    task automatic axil_write(input logic [15:0] offset, input axil_pkg::axil_data_t data);
        @(posedge clk);
        axil_req.awaddr  <= {16'h0000, offset};
        axil_req.wdata   <= data;
        axil_req.awvalid <= 1'b1;
        axil_req.wvalid  <= 1'b1;
        @(negedge clk);
        while (!axil_rsp.awready) @(negedge clk);
        check(axil_rsp.wready && axil_rsp.bvalid,
              $sformatf("write of 0x%h: wready or bvalid missing with awready", offset));
        @(posedge clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        if (offset == `REG_ENABLE) en_m = data[0];
    endtask

    task automatic axil_read(input logic [15:0] offset);
        @(posedge clk);
        rd_offset = offset;
        axil_req.araddr  <= {16'h0000, offset};
        axil_req.arvalid <= 1'b1;
        @(negedge clk);
        while (!axil_rsp.rvalid) @(negedge clk);
        check(axil_rsp.arready,
              $sformatf("read of 0x%h: arready missing with rvalid", offset));
        @(posedge clk);
        axil_req.arvalid <= 1'b0;
    endtask

    task automatic issue_desc(input int ch);
        dma_desc_pkg::dma_desc_t d;
        int hold;
        d.pcie_addr  = {$urandom, $urandom};
        d.local_addr = $urandom;
        d.len        = 16'($urandom);
        d.tag        = 8'($urandom);
        hold         = 1 + ($urandom % 8);
        exp_desc[ch] = d;
        axil_write(ch == 0 ? `REG_RD_PCIE_LO : `REG_WR_PCIE_LO, d.pcie_addr[31:0]);
        axil_write(ch == 0 ? `REG_RD_PCIE_HI : `REG_WR_PCIE_HI, d.pcie_addr[63:32]);
        axil_write(ch == 0 ? `REG_RD_AXI : `REG_WR_AXI, d.local_addr);
        axil_write(ch == 0 ? `REG_RD_LEN : `REG_WR_LEN, {16'h0000, d.len});
        axil_write(ch == 0 ? `REG_RD_TAG : `REG_WR_TAG, {24'h000000, d.tag});
        @(negedge clk);
        check(desc_valid(ch), $sformatf("channel %0d valid did not follow the tag write", ch));
        repeat (hold) begin
            @(negedge clk);
            check(desc_valid(ch), $sformatf("channel %0d valid dropped without ready", ch));
        end
        @(posedge clk);
        if (ch == 0) read_desc_ready <= 1'b1;
        else write_desc_ready <= 1'b1;
        @(posedge clk);
        read_desc_ready  <= 1'b0;
        write_desc_ready <= 1'b0;
        @(negedge clk);
        check(!desc_valid(ch), $sformatf("channel %0d valid stayed high after ready", ch));
    endtask

    task automatic status_round(input int ch);
        dma_desc_pkg::dma_tag_t tag_v;
        int pops_before;
        tag_v = 8'($urandom);
        pops_before = (ch == 0) ? rd_pops : wr_pops;
        @(posedge clk);
        if (ch == 0) read_status <= '{tag: tag_v, valid: 1'b1};
        else write_status <= '{tag: tag_v, valid: 1'b1};
        @(negedge clk);
        check(irq, "irq low while a status is pending");
        axil_read(ch == 0 ? `REG_RD_STATUS : `REG_WR_STATUS);
        while (((ch == 0) ? rd_pops : wr_pops) == pops_before) @(negedge clk);
        // engine side drops the status after the ready pulse
        @(posedge clk);
        read_status  <= '0;
        write_status <= '0;
        @(negedge clk);
        check(!irq, "irq still high with no status pending");
        axil_read(ch == 0 ? `REG_RD_STATUS : `REG_WR_STATUS);
        @(negedge clk);
        check(((ch == 0) ? rd_pops : wr_pops) == pops_before + 1,
              $sformatf("channel %0d status ready pulse count wrong", ch));
    endtask

    task automatic stream_traffic(input int cycles);
        dma_desc_pkg::tlp_streams_t s;
        repeat (cycles) begin
            @(posedge clk);
            s = 12'($urandom);
            streams <= s;
            if (completes(s.rq)) cnt_m[0]++;
            if (completes(s.rc)) cnt_m[1]++;
            if (completes(s.cq)) cnt_m[2]++;
            if (completes(s.cc)) cnt_m[3]++;
        end
        @(posedge clk);
        streams <= '0;
        axil_read(`REG_CNT_RQ);
        axil_read(`REG_CNT_RC);
        axil_read(`REG_CNT_CQ);
        axil_read(`REG_CNT_CC);
    endtask

    // gaps of 10 or more cycles keep the pending count well below 15
    task automatic error_bursts(input int bursts);
        logic [`ERR_SOURCES-1:0] c;
        logic [`ERR_SOURCES-1:0] u;
        repeat (bursts) begin
            repeat (1 + ($urandom % 4)) begin
                @(posedge clk);
                c = `ERR_SOURCES'($urandom);
                u = `ERR_SOURCES'($urandom);
                err_cor   <= c;
                err_uncor <= u;
                cor_in   += $countones(c);
                uncor_in += $countones(u);
            end
            @(posedge clk);
            err_cor   <= '0;
            err_uncor <= '0;
            repeat (10 + ($urandom % 6)) @(posedge clk);
        end
        @(negedge clk);
        while (status_error_cor || status_error_uncor) @(negedge clk);
        check(cor_out == cor_in,
              $sformatf("%0d correctable pulses out, %0d in", cor_out, cor_in));
        check(uncor_out == uncor_in,
              $sformatf("%0d uncorrectable pulses out, %0d in", uncor_out, uncor_in));
    endtask

    task automatic enable_roundtrip();
        axil_pkg::axil_data_t w;
        for (int i = 0; i < 4; i++) begin
            w = $urandom;
            w[0] = i[0];
            axil_write(`REG_ENABLE, w);
            @(negedge clk);
            check(dma_enable === w[0],
                  $sformatf("dma_enable is %b after writing 0x%h", dma_enable, w));
            axil_read(`REG_ENABLE);
        end
    endtask

    initial begin
        void'($urandom(4));
        rst              = 1'b1;
        axil_req         = '0;
        axil_req.bready  = 1'b1;
        axil_req.rready  = 1'b1;
        read_desc_ready  = 1'b0;
        write_desc_ready = 1'b0;
        read_status      = '0;
        write_status     = '0;
        streams          = '0;
        err_cor          = '0;
        err_uncor        = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check(!dma_enable && !read_desc_valid && !write_desc_valid, "outputs high after reset");
        check(!axil_rsp.bvalid && !axil_rsp.rvalid && !irq, "responses or irq high after reset");
        check(!axil_rsp.awready && !axil_rsp.wready && !axil_rsp.arready,
              "bus ready outputs high after reset");
        check(!read_status_ready && !write_status_ready, "status ready high after reset");
        check(!status_error_cor && !status_error_uncor, "error outputs high after reset");
        axil_read(`REG_ENABLE);
        axil_read(`REG_CNT_RQ);
        axil_read(`REG_CNT_RC);
        axil_read(`REG_CNT_CQ);
        axil_read(`REG_CNT_CC);

        for (int i = 0; i < 4; i++) begin
            issue_desc(i % 2);
        end
        status_round(0);
        status_round(1);
        stream_traffic(300);
        error_bursts(20);
        enable_roundtrip();

        @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: src/dma_ctrl_top.sv
`timescale 1ns/100ps

`include "dma_ctrl_defs.svh"

module dma_ctrl_top (
    input  logic                        clk,
    input  logic                        rst,
    input  axil_pkg::axil_req_t         axil_req,
    output axil_pkg::axil_rsp_t         axil_rsp,
    output logic                        dma_enable,
    output dma_desc_pkg::dma_desc_t     read_desc,
    output logic                        read_desc_valid,
    input  logic                        read_desc_ready,
    input  dma_desc_pkg::desc_status_t  read_status,
    output logic                        read_status_ready,
    output dma_desc_pkg::dma_desc_t     write_desc,
    output logic                        write_desc_valid,
    input  logic                        write_desc_ready,
    input  dma_desc_pkg::desc_status_t  write_status,
    output logic                        write_status_ready,
    input  dma_desc_pkg::tlp_streams_t  streams,
    input  logic [`ERR_SOURCES-1:0]     err_cor,
    input  logic [`ERR_SOURCES-1:0]     err_uncor,
    output logic                        status_error_cor,
    output logic                        status_error_uncor,
    output logic                        irq
);

    axil_pkg::reg_wr_t    reg_wr;
    logic                 read_status_pop;
    logic                 write_status_pop;
    axil_pkg::axil_data_t rq_count;
    axil_pkg::axil_data_t rc_count;
    axil_pkg::axil_data_t cq_count;
    axil_pkg::axil_data_t cc_count;

    axil_reg_ctrl ctrl_i (
        .clk              (clk),
        .rst              (rst),
        .axil_req         (axil_req),
        .axil_rsp         (axil_rsp),
        .reg_wr           (reg_wr),
        .dma_enable       (dma_enable),
        .read_status      (read_status),
        .write_status     (write_status),
        .rq_count         (rq_count),
        .rc_count         (rc_count),
        .cq_count         (cq_count),
        .cc_count         (cc_count),
        .read_status_pop  (read_status_pop),
        .write_status_pop (write_status_pop)
    );

    dma_desc_regs desc_i (
        .clk                (clk),
        .rst                (rst),
        .reg_wr             (reg_wr),
        .read_status_pop    (read_status_pop),
        .write_status_pop   (write_status_pop),
        .dma_enable         (dma_enable),
        .read_desc          (read_desc),
        .read_desc_valid    (read_desc_valid),
        .read_desc_ready    (read_desc_ready),
        .write_desc         (write_desc),
        .write_desc_valid   (write_desc_valid),
        .write_desc_ready   (write_desc_ready),
        .read_status        (read_status),
        .write_status       (write_status),
        .read_status_ready  (read_status_ready),
        .write_status_ready (write_status_ready),
        .irq                (irq)
    );

    tlp_counters counters_i (
        .clk      (clk),
        .rst      (rst),
        .streams  (streams),
        .rq_count (rq_count),
        .rc_count (rc_count),
        .cq_count (cq_count),
        .cc_count (cc_count)
    );

    // one merged pulse train per error class
    error_pulse_merge #(
        .sources (`ERR_SOURCES)
    ) err_cor_i (
        .clk       (clk),
        .rst       (rst),
        .pulse_in  (err_cor),
        .pulse_out (status_error_cor)
    );

    error_pulse_merge #(
        .sources (`ERR_SOURCES)
    ) err_uncor_i (
        .clk       (clk),
        .rst       (rst),
        .pulse_in  (err_uncor),
        .pulse_out (status_error_uncor)
    );

endmodule

// File: src/error_pulse_merge.sv
`timescale 1ns/100ps

`include "dma_ctrl_defs.svh"

module error_pulse_merge #(
    parameter int sources = 3
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [sources-1:0] pulse_in,
    output logic               pulse_out
);

    localparam int count_max = (1 << `ERR_COUNT_WIDTH) - 1;

    logic [`ERR_COUNT_WIDTH-1:0] count_q;
    logic [`ERR_COUNT_WIDTH-1:0] count_next;
    int                          next_val;

    // add new pulses, drain one per cycle, clamp at the top
    always_comb begin
        next_val = int'(count_q) + $countones(pulse_in);
        if (count_q != '0) begin
            next_val = next_val - 1;
        end
        if (next_val > count_max) begin
            next_val = count_max;
        end
        count_next = next_val[`ERR_COUNT_WIDTH-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else begin
            count_q <= count_next;
        end
    end

    assign pulse_out = (count_q != '0);

    count_no_wrap_a: assert property (@(posedge clk) disable iff (rst)
        count_q != '0 |=> count_q >= $past(count_q) - 1'b1);

endmodule

// File: src/tlp_counters.sv
`timescale 1ns/100ps

module tlp_counters (
    input  logic                        clk,
    input  logic                        rst,
    input  dma_desc_pkg::tlp_streams_t  streams,
    output axil_pkg::axil_data_t        rq_count,
    output axil_pkg::axil_data_t        rc_count,
    output axil_pkg::axil_data_t        cq_count,
    output axil_pkg::axil_data_t        cc_count
);

    dma_desc_pkg::tlp_beat_t beats [4];
    axil_pkg::axil_data_t    count_q [4];

    assign beats = '{streams.rq, streams.rc, streams.cq, streams.cc};

    // one count per completed TLP, wraps at 2**32
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (rst) begin
                count_q[i] <= '0;
            end else if (beats[i].valid && beats[i].ready && beats[i].last) begin
                count_q[i] <= count_q[i] + 1'b1;
            end
        end
    end

    assign rq_count = count_q[0];
    assign rc_count = count_q[1];
    assign cq_count = count_q[2];
    assign cc_count = count_q[3];

endmodule

// File: src/dma_desc_regs.sv
`timescale 1ns/100ps

`include "dma_ctrl_defs.svh"

module dma_desc_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  axil_pkg::reg_wr_t           reg_wr,
    input  logic                        read_status_pop,
    input  logic                        write_status_pop,
    output logic                        dma_enable,
    output dma_desc_pkg::dma_desc_t     read_desc,
    output logic                        read_desc_valid,
    input  logic                        read_desc_ready,
    output dma_desc_pkg::dma_desc_t     write_desc,
    output logic                        write_desc_valid,
    input  logic                        write_desc_ready,
    input  dma_desc_pkg::desc_status_t  read_status,
    input  dma_desc_pkg::desc_status_t  write_status,
    output logic                        read_status_ready,
    output logic                        write_status_ready,
    output logic                        irq
);

    // channel 0 is read, channel 1 is write
    localparam logic [`REG_ADDR_BITS-1:0] off_pcie_lo [2] = '{`REG_RD_PCIE_LO, `REG_WR_PCIE_LO};
    localparam logic [`REG_ADDR_BITS-1:0] off_pcie_hi [2] = '{`REG_RD_PCIE_HI, `REG_WR_PCIE_HI};
    localparam logic [`REG_ADDR_BITS-1:0] off_axi [2]     = '{`REG_RD_AXI, `REG_WR_AXI};
    localparam logic [`REG_ADDR_BITS-1:0] off_len [2]     = '{`REG_RD_LEN, `REG_WR_LEN};
    localparam logic [`REG_ADDR_BITS-1:0] off_tag [2]     = '{`REG_RD_TAG, `REG_WR_TAG};

    localparam int len_bits = $bits(dma_desc_pkg::dma_len_t);
    localparam int tag_bits = $bits(dma_desc_pkg::dma_tag_t);

    dma_desc_pkg::dma_desc_t desc_q [2];
    logic [1:0] valid_q;
    logic [1:0] desc_ready;
    logic [1:0] tag_wr;
    logic [1:0] wr_hit;
    logic       enable_q;
    logic       rd_status_ready_q;
    logic       wr_status_ready_q;

    assign desc_ready = {write_desc_ready, read_desc_ready};

    always_comb begin
        for (int ch = 0; ch < 2; ch++) begin
            tag_wr[ch] = reg_wr.valid && (reg_wr.addr == off_tag[ch]);
            wr_hit[ch] = reg_wr.valid && ((reg_wr.addr == off_pcie_lo[ch]) ||
                         (reg_wr.addr == off_pcie_hi[ch]) || (reg_wr.addr == off_axi[ch]) ||
                         (reg_wr.addr == off_len[ch]) || (reg_wr.addr == off_tag[ch]));
        end
    end

    // descriptor fields
    always_ff @(posedge clk) begin
        for (int ch = 0; ch < 2; ch++) begin
            if (reg_wr.valid && reg_wr.addr == off_pcie_lo[ch]) begin
                desc_q[ch].pcie_addr[31:0] <= reg_wr.data;
            end
            if (reg_wr.valid && reg_wr.addr == off_pcie_hi[ch]) begin
                desc_q[ch].pcie_addr[63:32] <= reg_wr.data;
            end
            if (reg_wr.valid && reg_wr.addr == off_axi[ch]) begin
                desc_q[ch].local_addr <= reg_wr.data;
            end
            if (reg_wr.valid && reg_wr.addr == off_len[ch]) begin
                desc_q[ch].len <= reg_wr.data[len_bits-1:0];
            end
            if (tag_wr[ch]) begin
                desc_q[ch].tag <= reg_wr.data[tag_bits-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q           <= '0;
            enable_q          <= 1'b0;
            rd_status_ready_q <= 1'b0;
            wr_status_ready_q <= 1'b0;
        end else begin
            // a tag write wins over a ready in the same cycle
            for (int ch = 0; ch < 2; ch++) begin
                if (tag_wr[ch]) begin
                    valid_q[ch] <= 1'b1;
                end else if (desc_ready[ch]) begin
                    valid_q[ch] <= 1'b0;
                end
            end
            if (reg_wr.valid && reg_wr.addr == `REG_ENABLE) begin
                enable_q <= reg_wr.data[0];
            end
            rd_status_ready_q <= read_status_pop;
            wr_status_ready_q <= write_status_pop;
        end
    end

    assign dma_enable         = enable_q;
    assign read_desc          = desc_q[0];
    assign read_desc_valid    = valid_q[0];
    assign write_desc         = desc_q[1];
    assign write_desc_valid   = valid_q[1];
    assign read_status_ready  = rd_status_ready_q;
    assign write_status_ready = wr_status_ready_q;
    assign irq                = read_status.valid || write_status.valid;

    for (genvar ch = 0; ch < 2; ch++) begin : g_hold
        desc_hold_a: assert property (@(posedge clk) disable iff (rst)
            valid_q[ch] && !desc_ready[ch] && !wr_hit[ch] |=>
                valid_q[ch] && $stable(desc_q[ch]));
    end

endmodule

// File: src/axil_reg_ctrl.sv
`timescale 1ns/100ps

`include "dma_ctrl_defs.svh"

module axil_reg_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  axil_pkg::axil_req_t         axil_req,
    output axil_pkg::axil_rsp_t         axil_rsp,
    output axil_pkg::reg_wr_t           reg_wr,
    input  logic                        dma_enable,
    input  dma_desc_pkg::desc_status_t  read_status,
    input  dma_desc_pkg::desc_status_t  write_status,
    input  axil_pkg::axil_data_t        rq_count,
    input  axil_pkg::axil_data_t        rc_count,
    input  axil_pkg::axil_data_t        cq_count,
    input  axil_pkg::axil_data_t        cc_count,
    output logic                        read_status_pop,
    output logic                        write_status_pop
);

    localparam int tag_bits = $bits(dma_desc_pkg::dma_tag_t);

    axil_pkg::resp_state_t wr_state_q;
    axil_pkg::resp_state_t rd_state_q;

    logic                       wr_accept;
    logic                       rd_accept;
    logic [`REG_ADDR_BITS-1:0]  wr_offset;
    logic [`REG_ADDR_BITS-1:0]  rd_offset;
    axil_pkg::axil_data_t       rd_word;

    logic                       wr_ack_q;
    logic                       rd_ack_q;
    logic                       wr_strobe_q;
    logic [`REG_ADDR_BITS-1:0]  wr_addr_q;
    axil_pkg::axil_data_t       wr_data_q;
    axil_pkg::axil_data_t       rdata_q;

    // address and data must arrive together
    assign wr_accept = axil_req.awvalid && axil_req.wvalid &&
                       (wr_state_q == axil_pkg::resp_idle);
    assign rd_accept = axil_req.arvalid && (rd_state_q == axil_pkg::resp_idle);

    assign wr_offset = {axil_req.awaddr[`REG_ADDR_BITS-1:2], 2'b00};
    assign rd_offset = {axil_req.araddr[`REG_ADDR_BITS-1:2], 2'b00};

    // read decode, status pops only when something is there
    always_comb begin
        rd_word          = '0;
        read_status_pop  = 1'b0;
        write_status_pop = 1'b0;
        case (rd_offset)
            `REG_ENABLE: rd_word[0] = dma_enable;
            `REG_RD_STATUS: begin
                rd_word[tag_bits-1:0]        = read_status.tag;
                rd_word[`STATUS_VALID_BIT]   = read_status.valid;
                read_status_pop              = rd_accept && read_status.valid;
            end
            `REG_WR_STATUS: begin
                rd_word[tag_bits-1:0]        = write_status.tag;
                rd_word[`STATUS_VALID_BIT]   = write_status.valid;
                write_status_pop             = rd_accept && write_status.valid;
            end
            `REG_CNT_RQ: rd_word = rq_count;
            `REG_CNT_RC: rd_word = rc_count;
            `REG_CNT_CQ: rd_word = cq_count;
            `REG_CNT_CC: rd_word = cc_count;
            default: rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state_q  <= axil_pkg::resp_idle;
            rd_state_q  <= axil_pkg::resp_idle;
            wr_ack_q    <= 1'b0;
            rd_ack_q    <= 1'b0;
            wr_strobe_q <= 1'b0;
        end else begin
            wr_ack_q    <= wr_accept;
            rd_ack_q    <= rd_accept;
            wr_strobe_q <= wr_accept;
            case (wr_state_q)
                axil_pkg::resp_idle:    if (wr_accept) wr_state_q <= axil_pkg::resp_pending;
                axil_pkg::resp_pending: if (axil_req.bready) wr_state_q <= axil_pkg::resp_idle;
                default:                wr_state_q <= axil_pkg::resp_idle;
            endcase
            case (rd_state_q)
                axil_pkg::resp_idle:    if (rd_accept) rd_state_q <= axil_pkg::resp_pending;
                axil_pkg::resp_pending: if (axil_req.rready) rd_state_q <= axil_pkg::resp_idle;
                default:                rd_state_q <= axil_pkg::resp_idle;
            endcase
        end
    end

    // payload, held until the next accept
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            wr_addr_q <= wr_offset;
            wr_data_q <= axil_req.wdata;
        end
        if (rd_accept) begin
            rdata_q <= rd_word;
        end
    end

    assign reg_wr = '{valid: wr_strobe_q, addr: wr_addr_q, data: wr_data_q};

    always_comb begin
        axil_rsp.awready = wr_ack_q;
        axil_rsp.wready  = wr_ack_q;
        axil_rsp.bvalid  = (wr_state_q == axil_pkg::resp_pending);
        axil_rsp.arready = rd_ack_q;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rvalid  = (rd_state_q == axil_pkg::resp_pending);
    end

    bvalid_hold_a: assert property (@(posedge clk) disable iff (rst)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid);

    rvalid_hold_a: assert property (@(posedge clk) disable iff (rst)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata));

endmodule

// File: src/dma_desc_pkg.sv
package dma_desc_pkg;

    typedef logic [63:0] pcie_addr_t;
    typedef logic [31:0] local_addr_t;
    typedef logic [15:0] dma_len_t;
    typedef logic [7:0]  dma_tag_t;

    // one transfer request for the DMA engine
    typedef struct packed {
        pcie_addr_t  pcie_addr;
        local_addr_t local_addr;
        dma_len_t    len;
        dma_tag_t    tag;
    } dma_desc_t;

    // completion report from the engine
    typedef struct packed {
        dma_tag_t tag;
        logic     valid;
    } desc_status_t;

    // handshake view of one TLP stream
    typedef struct packed {
        logic valid;
        logic ready;
        logic last;
    } tlp_beat_t;

    typedef struct packed {
        tlp_beat_t rq;
        tlp_beat_t rc;
        tlp_beat_t cq;
        tlp_beat_t cc;
    } tlp_streams_t;

endpackage

// File: src/axil_pkg.sv
`include "dma_ctrl_defs.svh"

package axil_pkg;

    typedef logic [31:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;

    // master side of the AXI-Lite port
    typedef struct packed {
        axil_addr_t awaddr;
        logic       awvalid;
        axil_data_t wdata;
        logic       wvalid;
        logic       bready;
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    // slave side, responses are always OKAY
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic       arready;
        axil_data_t rdata;
        logic       rvalid;
    } axil_rsp_t;

    // one-cycle register write strobe with word-aligned offset
    typedef struct packed {
        logic                       valid;
        logic [`REG_ADDR_BITS-1:0]  addr;
        axil_data_t                 data;
    } reg_wr_t;

    typedef enum logic {
        resp_idle,
        resp_pending
    } resp_state_t;

endpackage

// File: src/dma_ctrl_defs.svh
`ifndef DMA_CTRL_DEFS_SVH
`define DMA_CTRL_DEFS_SVH

// register map, byte offsets within the control window
`define REG_ENABLE       16'h0000

`define REG_RD_PCIE_LO   16'h0100
`define REG_RD_PCIE_HI   16'h0104
`define REG_RD_AXI       16'h0108
`define REG_RD_LEN       16'h0110
`define REG_RD_TAG       16'h0114
`define REG_RD_STATUS    16'h0118

`define REG_WR_PCIE_LO   16'h0200
`define REG_WR_PCIE_HI   16'h0204
`define REG_WR_AXI       16'h0208
`define REG_WR_LEN       16'h0210
`define REG_WR_TAG       16'h0214
`define REG_WR_STATUS    16'h0218

`define REG_CNT_RQ       16'h0400
`define REG_CNT_RC       16'h0404
`define REG_CNT_CQ       16'h0408
`define REG_CNT_CC       16'h040C

// decoded address bits, upper address bits are ignored
`define REG_ADDR_BITS    16
`define STATUS_VALID_BIT 31

// error merge, pending count saturates at 2**width - 1
`define ERR_SOURCES      3
`define ERR_COUNT_WIDTH  4

`endif
